// ==== vlog.f ====
+incdir+tb
hdl/cache_cfg_pkg.sv
hdl/wb_bus_pkg.sv
hdl/dcache.sv
hdl/wb_rr_arbiter.sv
hdl/wb_sram.sv
hdl/dcache_subsys.sv
tb/tb_dcache_subsys.sv

// ==== Bender.yml ====
package:
  name: dcache_subsys

sources:
  - files:
      - hdl/cache_cfg_pkg.sv
      - hdl/wb_bus_pkg.sv
      - hdl/dcache.sv
      - hdl/wb_rr_arbiter.sv
      - hdl/wb_sram.sv
      - hdl/dcache_subsys.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_dcache_subsys.sv

// ==== tb/tb_lfsr.svh ====
// Galois LFSR source of random stimulus
// Stepped once per bit taken, with address, data and byte-select pickers

`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

localparam logic [31:0] LFSR_SEED = 32'hc7a3_aa1c;
// Feedback taps for x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = LFSR_SEED;

// Shift out n bits, one LFSR step each, first bit ends up as the MSB
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		bits = {bits[30:0], lfsr_state[0]};
		lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
	end
	return bits;
endfunction

// Four tags over four sets, so twice as many lines as ways compete per set
function automatic cache_cfg_pkg::addr_t pick_addr();
	cache_cfg_pkg::tag_t  tag;
	cache_cfg_pkg::idx_t  idx;
	cache_cfg_pkg::woff_t woff;
	tag  = cache_cfg_pkg::tag_t'(take_bits(2));
	idx  = cache_cfg_pkg::idx_t'(take_bits(2));
	woff = cache_cfg_pkg::woff_t'(take_bits(cache_cfg_pkg::WOFF_W));
	return {tag, idx, woff, {cache_cfg_pkg::BOFF_W{1'b0}}};
endfunction

function automatic cache_cfg_pkg::word_t pick_data();
	return cache_cfg_pkg::word_t'(take_bits(cache_cfg_pkg::DATA_W));
endfunction

// An all-zero select would write nothing, so it becomes a full word
function automatic wb_bus_pkg::sel_t pick_sel();
	wb_bus_pkg::sel_t s;
	s = wb_bus_pkg::sel_t'(take_bits(wb_bus_pkg::SEL_W));
	if (s == '0)
		s = '1;
	return s;
endfunction

`endif

// ==== tb/tb_dcache_subsys.sv ====
// Testbench for the dual-channel data cache subsystem
// Drives both CPU ports, keeps a reference memory and checks every read by assertion

`timescale 1ns/10ps

module tb_dcache_subsys;

	localparam int CLK_PERIOD = 8;
	localparam int OP_TIMEOUT = 100;
	localparam int N_RAND     = 12;
	localparam int N_MIXED    = 40;
	// Operations of all tests together with a worst case of 40 cycles each
	localparam int N_OPS       = 4 + 7 + 2 * N_RAND + 8 + 7 + 5 + 2 * N_MIXED;
	localparam int WATCHDOG_NS = N_OPS * 40 * CLK_PERIOD + 2000;

	logic                clk;
	logic                rst;
	wb_bus_pkg::wb_req_t cpu_req [2];
	wb_bus_pkg::wb_rsp_t cpu_rsp [2];

	// Reference memory is word addressed like the SRAM
	cache_cfg_pkg::word_t ref_mem [wb_bus_pkg::MEM_WORDS];
	cache_cfg_pkg::word_t exp_dat [2];
	cache_cfg_pkg::addr_t cur_adr [2];
	logic [1:0]           busy;
	logic [1:0]           wr_busy;
	logic [1:0]           rd_chk;
	logic [1:0]           hit_chk;
	logic [1:0]           req_made;
	int                   err_cnt;
	int                   test_cnt;
	int                   test_fail;
	int                   read_cnt;

	`include "tb_lfsr.svh"

	dcache_subsys dcache_subsys_i (
		.clk        (clk),
		.rst        (rst),
		.cpu0_req_i (cpu_req[0]),
		.cpu1_req_i (cpu_req[1]),
		.cpu0_rsp_o (cpu_rsp[0]),
		.cpu1_rsp_o (cpu_rsp[1])
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ======================================================================
	// Checks
	// ======================================================================
	for (genvar g = 0; g < 2; g++) begin : g_chk
		// Ack stays low from reset until the channel has asked for something
		a_idle_ack: assert property (@(posedge clk) !req_made[g] |-> !cpu_rsp[g].ack)
			else begin
				$display("%0t ns: cpu%0d_rsp_o.ack rose with no request made", $time, g);
				err_cnt++;
			end

		// Read data must match the model as it was when the read was issued
		a_read_data: assert property (@(posedge clk) disable iff (rst)
			(rd_chk[g] && cpu_rsp[g].ack) |-> (cpu_rsp[g].dat == exp_dat[g]))
			else begin
				$display("[FAIL] %0t ns cpu%0d_rsp_o.dat expected %h actual %h", $time, g,
					$sampled(exp_dat[g]), $sampled(cpu_rsp[g].dat));
				err_cnt++;
			end

		// A hit answers two cycles after the request edge and is seen here one edge later
		a_hit_latency: assert property (@(posedge clk) disable iff (rst)
			($rose(cpu_req[g].cyc && cpu_req[g].stb) && hit_chk[g])
			|-> !cpu_rsp[g].ack [*3] ##1 cpu_rsp[g].ack)
			else begin
				$display("%0t ns: hit on channel %0d not acknowledged after 2 cycles", $time, g);
				err_cnt++;
			end
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic int word_of(input cache_cfg_pkg::addr_t adr);
		return int'(adr[cache_cfg_pkg::BOFF_W +: wb_bus_pkg::MEM_AW]);
	endfunction

	function automatic cache_cfg_pkg::word_t merge_bytes(input cache_cfg_pkg::word_t old_w,
			input cache_cfg_pkg::word_t new_w, input wb_bus_pkg::sel_t sel);
		cache_cfg_pkg::word_t res;
		res = old_w;
		for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic cache_cfg_pkg::addr_t make_addr(input int tag, input int idx,
			input int woff);
		return {cache_cfg_pkg::tag_t'(tag), cache_cfg_pkg::idx_t'(idx),
			cache_cfg_pkg::woff_t'(woff), {cache_cfg_pkg::BOFF_W{1'b0}}};
	endfunction

	// Called on a falling edge to put a request on one channel and update the model
	task automatic start_op(input int ch, input logic we, input cache_cfg_pkg::addr_t adr,
			input wb_bus_pkg::sel_t sel, input cache_cfg_pkg::word_t dat, input logic want_hit);
		int oth;
		oth = 1 - ch;
		cpu_req[ch]  = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
		req_made[ch] = 1'b1;
		busy[ch]     = 1'b1;
		cur_adr[ch]  = adr;
		if (we) begin
			ref_mem[word_of(adr)] = merge_bytes(ref_mem[word_of(adr)], dat, sel);
			wr_busy[ch] = 1'b1;
			rd_chk[ch]  = 1'b0;
			// An open read of this word on the other side may now see either value
			if (busy[oth] && rd_chk[oth] && word_of(cur_adr[oth]) == word_of(adr)) begin
				rd_chk[oth] = 1'b0;
				read_cnt--;
			end
		end else begin
			exp_dat[ch] = ref_mem[word_of(adr)];
			rd_chk[ch]  = !(wr_busy[oth] && word_of(cur_adr[oth]) == word_of(adr));
			hit_chk[ch] = want_hit;
			if (rd_chk[ch])
				read_cnt++;
		end
	endtask

	// The read check flag stays set until the next request
	// The ack is sampled on the rising edge after this falling edge
	task automatic finish_op(input int ch);
		cpu_req[ch] = '0;
		busy[ch]    = 1'b0;
		wr_busy[ch] = 1'b0;
		hit_chk[ch] = 1'b0;
	endtask

	task automatic drop_stuck(input int ch);
		$display("%0t ns: request on channel %0d to address %h was never acknowledged",
			$time, ch, cur_adr[ch]);
		err_cnt++;
		finish_op(ch);
	endtask

	// One request on one channel that waits for its ack
	task automatic do_op(input int ch, input logic we, input cache_cfg_pkg::addr_t adr,
			input wb_bus_pkg::sel_t sel, input cache_cfg_pkg::word_t dat, input logic want_hit);
		int waited;
		waited = 0;
		@(negedge clk);
		start_op(ch, we, adr, sel, dat, want_hit);
		while (busy[ch]) begin
			@(negedge clk);
			waited++;
			if (cpu_rsp[ch].ack)
				finish_op(ch);
			else if (waited >= OP_TIMEOUT)
				drop_stuck(ch);
		end
	endtask

	task automatic do_read(input int ch, input cache_cfg_pkg::addr_t adr, input logic want_hit);
		do_op(ch, 1'b0, adr, '1, '0, want_hit);
	endtask

	task automatic do_write(input int ch, input cache_cfg_pkg::addr_t adr,
			input wb_bus_pkg::sel_t sel, input cache_cfg_pkg::word_t dat);
		do_op(ch, 1'b1, adr, sel, dat, 1'b0);
	endtask

	// Both channels run in one process so both sides see a fixed order
	task automatic run_mixed(input int n);
		int                   issued [2];
		int                   waited [2];
		logic [1:0]           cooled;
		logic                 we;
		cache_cfg_pkg::addr_t adr;
		issued = '{0, 0};
		waited = '{0, 0};
		while (issued[0] < n || issued[1] < n || busy != 2'b00) begin
			@(negedge clk);
			cooled = 2'b00;
			for (int ch = 0; ch < 2; ch++) begin
				if (busy[ch]) begin
					waited[ch]++;
					if (cpu_rsp[ch].ack) begin
						finish_op(ch);
						cooled[ch] = 1'b1;
					end else if (waited[ch] >= OP_TIMEOUT) begin
						drop_stuck(ch);
					end
				end
			end
			// A channel that just finished leaves one idle cycle before the next request
			for (int ch = 0; ch < 2; ch++) begin
				if (!busy[ch] && !cooled[ch] && issued[ch] < n && take_bits(1) == 1) begin
					adr = pick_addr();
					we  = take_bits(1) == 1;
					// Two writes to one word in flight would leave memory order open
					if (we && wr_busy[1-ch] && word_of(cur_adr[1-ch]) == word_of(adr))
						we = 1'b0;
					start_op(ch, we, adr, pick_sel(), pick_data(), 1'b0);
					issued[ch]++;
					waited[ch] = 0;
				end
			end
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt != err_before)
			test_fail++;
		$display("Test %-16s %s, %0d errors", name,
			(err_cnt == err_before) ? "passed" : "FAILED", err_cnt - err_before);
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial begin
		int e0;
		cache_cfg_pkg::addr_t a;
		clk       = 1'b0;
		rst       = 1'b1;
		cpu_req   = '{default: '0};
		exp_dat   = '{default: '0};
		cur_adr   = '{default: '0};
		busy      = '0;
		wr_busy   = '0;
		rd_chk    = '0;
		hit_chk   = '0;
		req_made  = '0;
		err_cnt   = 0;
		test_cnt  = 0;
		test_fail = 0;
		read_cnt  = 0;
		for (int i = 0; i < wb_bus_pkg::MEM_WORDS; i++)
			ref_mem[i] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Acks must stay quiet for a while and then untouched memory reads as zero
		e0 = err_cnt;
		repeat (4) @(negedge clk);
		for (int i = 0; i < 4; i++)
			do_read(i % 2, pick_addr(), 1'b0);
		end_test("reset_state", e0);

		// Three tags in set 5 force an LRU eviction on a two-way cache
		e0 = err_cnt;
		for (int t = 1; t <= 3; t++)
			do_write(0, make_addr(t, 5, t - 1), '1, pick_data());
		for (int t = 1; t <= 3; t++)
			do_read(0, make_addr(t, 5, t - 1), 1'b0);
		do_read(0, make_addr(1, 5, 0), 1'b0);
		for (int i = 0; i < N_RAND; i++) begin
			a = pick_addr();
			do_write(i % 2, a, pick_sel(), pick_data());
			do_read(i % 2, a, 1'b0);
		end
		end_test("read_after_write", e0);

		// The first read fills and the second one must hit
		e0 = err_cnt;
		for (int i = 0; i < 4; i++) begin
			a = pick_addr();
			do_read(1, a, 1'b0);
			do_read(1, a, 1'b1);
		end
		end_test("hit_latency", e0);

		// Partial writes to a cached word are each read back as a hit
		e0 = err_cnt;
		a = make_addr(2, 9, 3);
		do_read(0, a, 1'b0);
		do_write(0, a, 4'b0101, pick_data());
		do_read(0, a, 1'b1);
		do_write(0, a, 4'b1000, pick_data());
		do_read(0, a, 1'b1);
		do_write(0, a, 4'b0010, pick_data());
		do_read(0, a, 1'b1);
		end_test("byte_merge", e0);

		// Channel 1 writes a line that channel 0 holds
		e0 = err_cnt;
		a = make_addr(3, 12, 1);
		do_read(0, a, 1'b0);
		do_read(0, a, 1'b1);
		do_write(1, a, '1, pick_data());
		do_read(0, a, 1'b0);
		do_read(0, a, 1'b1);
		end_test("coherence", e0);

		e0 = err_cnt;
		run_mixed(N_MIXED);
		end_test("concurrent", e0);

		repeat (4) @(negedge clk);
		$display("Tests %0d, failed %0d, reads checked %0d, errors %0d",
			test_cnt, test_fail, read_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog sized from the operation count of all tests
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== hdl/dcache_subsys.sv ====
// Dual-channel data cache subsystem
// Two write-through caches sharing one memory through a round-robin arbiter

`timescale 1ns/10ps

module dcache_subsys (
	input  logic                clk,
	input  logic                rst,
	input  wb_bus_pkg::wb_req_t cpu0_req_i,
	input  wb_bus_pkg::wb_req_t cpu1_req_i,
	output wb_bus_pkg::wb_rsp_t cpu0_rsp_o,
	output wb_bus_pkg::wb_rsp_t cpu1_rsp_o
);

	// Memory side of each cache, indexed by channel
	wb_bus_pkg::wb_req_t mem_req [wb_bus_pkg::N_MASTERS];
	wb_bus_pkg::wb_rsp_t mem_rsp [wb_bus_pkg::N_MASTERS];
	wb_bus_pkg::wb_req_t sram_req;
	wb_bus_pkg::wb_rsp_t sram_rsp;
	wb_bus_pkg::snoop_t  snoop;

	dcache #(.CHAN_ID(1'b0)) dcache0_i (
		.clk       (clk),
		.rst       (rst),
		.cpu_req_i (cpu0_req_i),
		.cpu_rsp_o (cpu0_rsp_o),
		.mem_req_o (mem_req[0]),
		.mem_rsp_i (mem_rsp[0]),
		.snoop_i   (snoop)
	);

	dcache #(.CHAN_ID(1'b1)) dcache1_i (
		.clk       (clk),
		.rst       (rst),
		.cpu_req_i (cpu1_req_i),
		.cpu_rsp_o (cpu1_rsp_o),
		.mem_req_o (mem_req[1]),
		.mem_rsp_i (mem_rsp[1]),
		.snoop_i   (snoop)
	);

	wb_rr_arbiter arbiter_i (
		.clk     (clk),
		.rst     (rst),
		.m_req_i (mem_req),
		.m_rsp_o (mem_rsp),
		.s_req_o (sram_req),
		.s_rsp_i (sram_rsp),
		.snoop_o (snoop)
	);

	wb_sram sram_i (
		.clk   (clk),
		.rst   (rst),
		.req_i (sram_req),
		.rsp_o (sram_rsp)
	);

endmodule

// ==== hdl/wb_sram.sv ====
// Wishbone classic memory slave
// One wait state, registered read data and byte-select writes

`timescale 1ns/10ps

module wb_sram (
	input  logic                clk,
	input  logic                rst,
	input  wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o
);

	cache_cfg_pkg::word_t          mem [wb_bus_pkg::MEM_WORDS];
	logic [wb_bus_pkg::MEM_AW-1:0] widx;
	logic                          access;
	logic                          ack_q;
	cache_cfg_pkg::word_t          dat_q;

	// Word address, upper bits above the array depth alias
	assign widx = req_i.adr[cache_cfg_pkg::BOFF_W +: wb_bus_pkg::MEM_AW];

	// The cycle carrying ack is not a new access even if stb is still high
	assign access = req_i.cyc && req_i.stb && !ack_q;

	// Memory contents start out as zero
	initial begin
		for (int i = 0; i < wb_bus_pkg::MEM_WORDS; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// Read returns the word as it was before a write in the same access
	always_ff @(posedge clk) begin
		if (access) begin
			dat_q <= mem[widx];
			if (req_i.we) begin
				for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
					if (req_i.sel[b])
						mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

// ==== hdl/wb_rr_arbiter.sv ====
// Round-robin arbiter for two Wishbone classic masters
// Grants on an idle bus, holds the grant while cyc stays high
// and broadcasts the address of every acknowledged write as a snoop

`timescale 1ns/10ps

module wb_rr_arbiter (
	input  logic                clk,
	input  logic                rst,
	input  wb_bus_pkg::wb_req_t m_req_i [wb_bus_pkg::N_MASTERS],
	output wb_bus_pkg::wb_rsp_t m_rsp_o [wb_bus_pkg::N_MASTERS],
	output wb_bus_pkg::wb_req_t s_req_o,
	input  wb_bus_pkg::wb_rsp_t s_rsp_i,
	output wb_bus_pkg::snoop_t  snoop_o
);

	typedef enum logic {A_IDLE, A_BUSY} arb_state_t;

	arb_state_t           state;
	cache_cfg_pkg::chan_t gnt;
	// Master that wins a tie on the next grant
	cache_cfg_pkg::chan_t prio;
	cache_cfg_pkg::chan_t pick;
	logic                 any_req;
	logic                 wr_done;
	logic                 snp_valid;
	cache_cfg_pkg::addr_t snp_adr;
	cache_cfg_pkg::chan_t snp_src;

	assign any_req = m_req_i[0].cyc || m_req_i[1].cyc;
	assign pick    = m_req_i[prio].cyc ? prio : ~prio;

	// Grant FSM, the master just granted drops to low priority
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= A_IDLE;
			gnt   <= '0;
			prio  <= '0;
		end else begin
			case (state)
				A_IDLE: begin
					if (any_req) begin
						gnt   <= pick;
						prio  <= ~pick;
						state <= A_BUSY;
					end
				end
				A_BUSY: begin
					if (!m_req_i[gnt].cyc)
						state <= A_IDLE;
				end
				default:
					state <= A_IDLE;
			endcase
		end
	end

	// Pass-through of the granted master, nothing reaches memory while idle
	assign s_req_o = (state == A_BUSY) ? m_req_i[gnt] : '0;

	always_comb begin
		for (int i = 0; i < wb_bus_pkg::N_MASTERS; i++) begin
			m_rsp_o[i].ack = s_rsp_i.ack && (state == A_BUSY)
				&& (gnt == cache_cfg_pkg::chan_t'(i));
			m_rsp_o[i].dat = s_rsp_i.dat;
		end
	end

	// ======================================================================
	// Snoop broadcast
	// ======================================================================
	assign wr_done = s_req_o.cyc && s_req_o.stb && s_req_o.we && s_rsp_i.ack;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			snp_valid <= 1'b0;
		else
			snp_valid <= wr_done;
	end

	always_ff @(posedge clk) begin
		if (wr_done) begin
			snp_adr <= s_req_o.adr;
			snp_src <= gnt;
		end
	end

	assign snoop_o = '{valid: snp_valid, adr: snp_adr, src: snp_src};

	// A line fill must never be split between two masters
	a_grant_held: assert property (@(posedge clk) disable iff (rst)
		(state == A_BUSY && m_req_i[gnt].cyc) |=> (state == A_BUSY && $stable(gnt)));

endmodule

// ==== hdl/dcache.sv ====
// Two-way set-associative write-through data cache
// Wishbone slave toward the CPU, Wishbone master toward memory
// Lines written by the other channel are dropped on snoop

`timescale 1ns/10ps

module dcache #(
	parameter cache_cfg_pkg::chan_t CHAN_ID = 1'b0
) (
	input  logic                clk,
	input  logic                rst,
	input  wb_bus_pkg::wb_req_t cpu_req_i,
	output wb_bus_pkg::wb_rsp_t cpu_rsp_o,
	output wb_bus_pkg::wb_req_t mem_req_o,
	input  wb_bus_pkg::wb_rsp_t mem_rsp_i,
	input  wb_bus_pkg::snoop_t  snoop_i
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_RESPOND,
		S_FILL,
		S_INSTALL,
		S_WRITE_THRU,
		S_WRITE_ACK
	} state_t;

	// ======================================================================
	// Storage
	// ======================================================================
	// Tag and data arrays have no reset, only the valid flops are cleared
	cache_cfg_pkg::tag_t  tag_mem  [cache_cfg_pkg::WAYS][cache_cfg_pkg::SETS];
	cache_cfg_pkg::word_t data_mem [cache_cfg_pkg::WAYS][cache_cfg_pkg::SETS*cache_cfg_pkg::LINE_WORDS];
	logic [cache_cfg_pkg::SETS-1:0] valid [cache_cfg_pkg::WAYS];
	// Per set, the way to replace next
	logic [cache_cfg_pkg::SETS-1:0] lru;

	state_t               state;
	wb_bus_pkg::wb_req_t  req_q;
	cache_cfg_pkg::tag_t  rd_tag  [cache_cfg_pkg::WAYS];
	cache_cfg_pkg::word_t rd_data [cache_cfg_pkg::WAYS];
	cache_cfg_pkg::tag_t  req_tag;
	cache_cfg_pkg::idx_t  req_idx;
	cache_cfg_pkg::woff_t req_woff;
	logic [cache_cfg_pkg::WAYS-1:0] hit;
	cache_cfg_pkg::way_t  hit_way;
	cache_cfg_pkg::way_t  victim;
	// Way being filled, or the way that a write hit
	cache_cfg_pkg::way_t  tgt_way;
	logic                 wr_hit;
	cache_cfg_pkg::woff_t cnt;
	cache_cfg_pkg::word_t req_word;
	logic                 fill_kill;
	logic                 accept;
	logic                 rsp_ack;
	cache_cfg_pkg::word_t rsp_dat;
	logic                 snp_other;
	cache_cfg_pkg::tag_t  snp_tag;
	cache_cfg_pkg::idx_t  snp_idx;
	logic                 snp_fill_hit;

	// ======================================================================
	// Address decode, hit and victim selection
	// ======================================================================
	assign req_tag  = req_q.adr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
	assign req_idx  = req_q.adr[cache_cfg_pkg::OFFS_W +: cache_cfg_pkg::IDX_W];
	assign req_woff = req_q.adr[cache_cfg_pkg::BOFF_W +: cache_cfg_pkg::WOFF_W];

	// A new request is taken only while idle and once the last ack is gone
	assign accept = (state == S_IDLE) && cpu_req_i.cyc && cpu_req_i.stb && !rsp_ack;

	// Valid bits are read live so a snoop between lookup and compare counts
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
			hit[w] = valid[w][req_idx] && (rd_tag[w] == req_tag);
			if (hit[w])
				hit_way = cache_cfg_pkg::way_t'(w);
		end
	end

	// An empty way wins over the LRU choice
	always_comb begin
		victim = cache_cfg_pkg::way_t'(lru[req_idx]);
		for (int w = cache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
			if (!valid[w][req_idx])
				victim = cache_cfg_pkg::way_t'(w);
		end
	end

	// Snoops from our own channel describe data we already hold
	assign snp_other = snoop_i.valid && (snoop_i.src != CHAN_ID);
	assign snp_tag   = snoop_i.adr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
	assign snp_idx   = snoop_i.adr[cache_cfg_pkg::OFFS_W +: cache_cfg_pkg::IDX_W];
	// The line under fill is not in tag_mem yet, so compare with the request
	assign snp_fill_hit = snp_other && (snp_tag == req_tag) && (snp_idx == req_idx);

	// ======================================================================
	// Memory side request
	// ======================================================================
	// cyc stays high through all words of a fill so the arbiter keeps us
	always_comb begin
		mem_req_o = '0;
		case (state)
			S_FILL: begin
				mem_req_o.cyc = 1'b1;
				mem_req_o.stb = 1'b1;
				mem_req_o.sel = '1;
				mem_req_o.adr = {req_tag, req_idx, cnt, {cache_cfg_pkg::BOFF_W{1'b0}}};
			end
			S_WRITE_THRU: begin
				mem_req_o.cyc = 1'b1;
				mem_req_o.stb = 1'b1;
				mem_req_o.we  = 1'b1;
				mem_req_o.sel = req_q.sel;
				mem_req_o.adr = req_q.adr;
				mem_req_o.dat = req_q.dat;
			end
			default: begin
			end
		endcase
	end

	assign cpu_rsp_o = '{ack: rsp_ack, dat: rsp_dat};

	// ======================================================================
	// Control FSM, valid and LRU state
	// ======================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= S_IDLE;
			cnt       <= '0;
			fill_kill <= 1'b0;
			rsp_ack   <= 1'b0;
			lru       <= '0;
			for (int w = 0; w < cache_cfg_pkg::WAYS; w++)
				valid[w] <= '0;
		end else begin
			rsp_ack <= 1'b0;
			// Snoop invalidation first, so an install below can still set valid
			if (snp_other) begin
				for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
					if (tag_mem[w][snp_idx] == snp_tag)
						valid[w][snp_idx] <= 1'b0;
				end
			end
			case (state)
				S_IDLE: begin
					if (accept)
						state <= S_LOOKUP;
				end
				S_LOOKUP:
					state <= S_RESPOND;
				S_RESPOND: begin
					if (req_q.we) begin
						state <= S_WRITE_THRU;
					end else if (|hit) begin
						rsp_ack      <= 1'b1;
						lru[req_idx] <= ~hit_way;
						state        <= S_IDLE;
					end else begin
						// The victim is unusable until the new line is complete
						valid[victim][req_idx] <= 1'b0;
						cnt       <= '0;
						fill_kill <= 1'b0;
						state     <= S_FILL;
					end
				end
				S_FILL: begin
					if (snp_fill_hit)
						fill_kill <= 1'b1;
					if (mem_rsp_i.ack) begin
						cnt <= cnt + 1'b1;
						if (cnt == cache_cfg_pkg::woff_t'(cache_cfg_pkg::LINE_WORDS - 1))
							state <= S_INSTALL;
					end
				end
				S_INSTALL: begin
					// A line written elsewhere during the fill may hold stale words
					valid[tgt_way][req_idx] <= !(fill_kill || snp_fill_hit);
					lru[req_idx] <= ~tgt_way;
					rsp_ack      <= 1'b1;
					state        <= S_IDLE;
				end
				S_WRITE_THRU: begin
					if (mem_rsp_i.ack) begin
						rsp_ack <= 1'b1;
						if (wr_hit)
							lru[req_idx] <= ~tgt_way;
						state <= S_WRITE_ACK;
					end
				end
				S_WRITE_ACK:
					state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Arrays and payload registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (accept)
			req_q <= cpu_req_i;
		case (state)
			S_LOOKUP: begin
				for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
					rd_tag[w]  <= tag_mem[w][req_idx];
					rd_data[w] <= data_mem[w][{req_idx, req_woff}];
				end
			end
			S_RESPOND: begin
				rsp_dat <= rd_data[hit_way];
				wr_hit  <= |hit;
				tgt_way <= (|hit) ? hit_way : victim;
			end
			S_FILL: begin
				if (mem_rsp_i.ack) begin
					data_mem[tgt_way][{req_idx, cnt}] <= mem_rsp_i.dat;
					// Keep the requested word for the answer after install
					if (cnt == req_woff)
						req_word <= mem_rsp_i.dat;
				end
			end
			S_INSTALL: begin
				tag_mem[tgt_way][req_idx] <= req_tag;
				rsp_dat <= req_word;
			end
			S_WRITE_THRU: begin
				// Merge only the enabled byte lanes into the cached word
				if (mem_rsp_i.ack && wr_hit) begin
					for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
						if (req_q.sel[b])
							data_mem[tgt_way][{req_idx, req_woff}][8*b +: 8] <= req_q.dat[8*b +: 8];
					end
				end
			end
			default: begin
			end
		endcase
	end

	// ======================================================================
	// Assertions
	// ======================================================================
	// The idle guard on rsp_ack keeps a held request from being served twice
	a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		cpu_rsp_o.ack |=> !cpu_rsp_o.ack);

	// Install, snoop and victim logic must never leave one tag in two ways
	a_one_hit: assert property (@(posedge clk) disable iff (rst)
		(state == S_RESPOND) |-> ($countones(hit) <= 1));

endmodule

// ==== hdl/wb_bus_pkg.sv ====
// Wishbone bus package
// Classic-cycle request and response structs plus the snoop broadcast

package wb_bus_pkg;

	// Masters on the shared memory bus
	localparam int N_MASTERS = 2;

	// Byte lanes of one data word
	localparam int SEL_W = cache_cfg_pkg::DATA_W / 8;
	typedef logic [SEL_W-1:0] sel_t;

	// Backing memory depth in words
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	// Driven by a master, held stable until ack
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		sel_t                  sel;
		cache_cfg_pkg::addr_t  adr;
		cache_cfg_pkg::word_t  dat;
	} wb_req_t;

	// Driven by a slave, ack is a single-cycle pulse
	typedef struct packed {
		logic                  ack;
		cache_cfg_pkg::word_t  dat;
	} wb_rsp_t;

	// Address of a write that completed on the memory bus
	typedef struct packed {
		logic                  valid;
		cache_cfg_pkg::addr_t  adr;
		cache_cfg_pkg::chan_t  src;
	} snoop_t;

endpackage

// ==== hdl/cache_cfg_pkg.sv ====
// Cache geometry package
// Sizes of the two-way data caches and the vector types built on them

package cache_cfg_pkg;

	// ======================================================================
	// Base geometry
	// ======================================================================
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 32;
	localparam int WAYS       = 2;
	localparam int SETS       = 16;
	localparam int LINE_WORDS = 4;

	// Address split: | tag | index | word in line | byte in word |
	localparam int BOFF_W = $clog2(DATA_W / 8);
	localparam int WOFF_W = $clog2(LINE_WORDS);
	localparam int OFFS_W = BOFF_W + WOFF_W;
	localparam int IDX_W  = $clog2(SETS);
	localparam int TAG_W  = ADDR_W - IDX_W - OFFS_W;

	// ======================================================================
	// Types
	// ======================================================================
	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [DATA_W-1:0]        word_t;
	typedef logic [TAG_W-1:0]         tag_t;
	typedef logic [IDX_W-1:0]         idx_t;
	typedef logic [WOFF_W-1:0]        woff_t;
	typedef logic [$clog2(WAYS)-1:0]  way_t;
	// One channel per processor, two in total
	typedef logic [0:0]               chan_t;

endpackage
